//--- all.f
rtl/rapid_pkg.sv
rtl/decoder_logic.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/rapid_decode_top.sv
bench/tb_rapid_decode.sv

//--- bench/decode_stimulus.txt
# grp cmd vld instr stall flush wb_en wb_rd wb_data, then expected one cycle later:
# ex_valid flags(lui,jal,br,mem,alui,alur,ill) iop rd rs1 rs2 f3 imm rs1_data rs2_data
# Groups: 1 decode, 2 illegal, 3 operands, 4 reset, 5 stall, 6 flush; W lines check ex_valid only
4 D 1 002081B3 0 0 0 00 00000000 1 02 0 03 01 02 0 00000000 00000000 00000000
4 D 1 41F28233 0 0 0 00 00000000 1 02 1 04 05 1F 0 00000000 00000000 00000000
1 D 1 ABCDE2B7 0 0 0 00 00000000 1 40 1 05 00 00 6 ABCDE000 00000000 00000000
1 D 1 00001397 0 0 0 00 00000000 1 40 0 07 00 00 1 00001000 00000000 00000000
1 D 1 FF9FF0EF 0 0 0 00 00000000 1 20 0 01 00 00 7 FFFFFFF8 00000000 00000000
1 D 1 01008167 0 0 0 00 00000000 1 20 1 02 01 00 0 00000010 00000000 00000000
1 D 1 FE209EE3 0 0 0 00 00000000 1 10 0 00 01 02 1 FFFFFFFC 00000000 00000000
1 D 1 FF42A303 0 0 0 00 00000000 1 08 0 06 05 00 2 FFFFFFF4 00000000 00000000
1 D 1 00742A23 0 0 0 00 00000000 1 08 1 00 08 07 2 00000014 00000000 00000000
1 D 1 FE208FA3 0 0 0 00 00000000 1 08 1 00 01 02 0 FFFFFFFF 00000000 00000000
1 D 1 80008493 0 0 0 00 00000000 1 04 0 09 01 00 0 FFFFF800 00000000 00000000
1 D 1 4030D513 0 0 0 00 00000000 1 04 1 0A 01 00 5 00000403 00000000 00000000
1 D 1 005145B3 0 0 0 00 00000000 1 02 0 0B 02 05 4 00000000 00000000 00000000
2 D 1 FFFFFFFF 0 0 0 00 00000000 1 01 0 00 00 00 7 00000000 00000000 00000000
2 D 1 00000073 0 0 0 00 00000000 1 01 0 00 00 00 0 00000000 00000000 00000000
3 W 0 00000000 0 0 1 01 12345678 0 00 0 00 00 00 0 00000000 00000000 00000000
3 W 0 00000000 0 0 1 02 FFFFFF00 0 00 0 00 00 00 0 00000000 00000000 00000000
3 W 0 00000000 0 0 1 05 CAFEBABE 0 00 0 00 00 00 0 00000000 00000000 00000000
3 W 0 00000000 0 0 1 00 DEADBEEF 0 00 0 00 00 00 0 00000000 00000000 00000000
3 D 1 002081B3 0 0 0 00 00000000 1 02 0 03 01 02 0 00000000 12345678 FFFFFF00
3 D 1 FE209EE3 0 0 0 00 00000000 1 10 0 00 01 02 1 FFFFFFFC 12345678 FFFFFF00
3 D 1 01008167 0 0 0 00 00000000 1 20 1 02 01 00 0 00000010 12345678 00000000
3 D 1 00510613 0 0 0 00 00000000 1 04 0 0C 02 00 0 00000005 FFFFFF00 00000000
3 D 1 005145B3 0 0 0 00 00000000 1 02 0 0B 02 05 4 00000000 FFFFFF00 CAFEBABE
3 D 1 000006B3 0 0 0 00 00000000 1 02 0 0D 00 00 0 00000000 00000000 00000000
3 D 1 000006B3 0 0 1 00 11111111 1 02 0 0D 00 00 0 00000000 00000000 00000000
3 D 1 00130733 0 0 1 06 0BADF00D 1 02 0 0E 06 01 0 00000000 0BADF00D 12345678
3 D 1 00130733 0 0 0 00 00000000 1 02 0 0E 06 01 0 00000000 0BADF00D 12345678
5 D 1 005145B3 0 0 0 00 00000000 1 02 0 0B 02 05 4 00000000 FFFFFF00 CAFEBABE
5 S 1 ABCDE2B7 1 0 0 00 00000000 1 02 0 0B 02 05 4 00000000 FFFFFF00 CAFEBABE
5 S 0 FFFFFFFF 1 0 1 05 00000055 1 02 0 0B 02 05 4 00000000 FFFFFF00 CAFEBABE
5 D 1 ABCDE2B7 0 0 0 00 00000000 1 40 1 05 00 00 6 ABCDE000 00000000 00000000
6 D 1 002081B3 0 0 0 00 00000000 1 02 0 03 01 02 0 00000000 12345678 FFFFFF00
6 F 1 005145B3 0 1 0 00 00000000 0 00 0 00 00 00 0 00000000 00000000 00000000
6 D 1 005145B3 0 0 0 00 00000000 1 02 0 0B 02 05 4 00000000 FFFFFF00 00000055
6 F 1 ABCDE2B7 1 1 0 00 00000000 0 00 0 00 00 00 0 00000000 00000000 00000000
6 D 0 002081B3 0 0 0 00 00000000 0 02 0 03 01 02 0 00000000 12345678 FFFFFF00
6 D 1 4030D513 0 0 0 00 00000000 1 04 1 0A 01 00 5 00000403 12345678 00000000

//--- bench/tb_rapid_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rapid_decode;

    localparam int    CLK_PERIOD    = 100;
    localparam int    RESET_GROUP   = 4;
    localparam int    MARGIN_CYCLES = 20;
    localparam string STIM_FILE     = "bench/decode_stimulus.txt";

    // One stimulus line with DUT inputs and expected outputs
    typedef struct packed {
        logic [7:0]  group;
        logic [7:0]  cmd;
        logic        valid;
        logic [31:0] instr;
        logic        stall;
        logic        flush;
        logic        wb_en;
        logic [4:0]  wb_rd;
        logic [31:0] wb_data;
        logic        exp_valid;
        logic [6:0]  exp_flags;
        logic        exp_iop;
        logic [4:0]  exp_rd;
        logic [4:0]  exp_rs1;
        logic [4:0]  exp_rs2;
        logic [2:0]  exp_f3;
        logic [31:0] exp_imm;
        logic [31:0] exp_rs1_data;
        logic [31:0] exp_rs2_data;
    } vector_s;

    logic                             clk;
    logic                             rst;
    logic                             instr_valid;
    logic [rapid_pkg::XLEN-1:0]       instruction;
    logic                             stall;
    logic                             flush;
    logic                             wb_en;
    logic [rapid_pkg::REG_ADDR_W-1:0] wb_rd;
    logic [rapid_pkg::XLEN-1:0]       wb_data;
    rapid_pkg::id_ex_s                ex;
    logic                             ex_valid;

    vector_s     vectors[$];
    logic        loaded;
    logic        load_ok;
    time         watchdog_ns;
    int          checks;
    int          errors;
    int          group_checks;
    int          group_errors;
    int          current_group;
    logic [31:0] held_instr;

    rapid_decode_top u_dut
    (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_instr_valid (instr_valid),
        .i_instruction (instruction),
        .i_stall       (stall),
        .i_flush       (flush),
        .i_wb_en       (wb_en),
        .i_wb_rd       (wb_rd),
        .i_wb_data     (wb_data),
        .o_ex          (ex),
        .o_ex_valid    (ex_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        group_checks++;
        if (actual !== expected)
        begin
            $display("** Error at %t: %s expected %h, actual %h", $time, name, expected, actual);
            errors++;
            group_errors++;
        end
    endtask

    function automatic string group_name(input int id);
        case (id)
            1:       return "family decode";
            2:       return "illegal opcode";
            3:       return "operands";
            4:       return "reset";
            5:       return "stall";
            6:       return "flush";
            default: return "unnamed";
        endcase
    endfunction

    task automatic finish_group();
        $display("Group %0d (%s) done: %0d checks, %0d errors", current_group,
                 group_name(current_group), group_checks, group_errors);
        group_checks = 0;
        group_errors = 0;
    endtask

    // Source registers read by each family, from the expected block flags
    // {lui, jump, branch, mem, alu_imm, alu_reg, illegal}
    function automatic logic [1:0] sources_used(input logic [6:0] flags, input logic iop);
        logic rs1_used;
        logic rs2_used;
        // Only JALR among jumps and only stores among memory ops
        rs1_used = (flags[5] && iop) || flags[4] || flags[3] || flags[2] || flags[1];
        rs2_used = flags[4] || (flags[3] && iop) || flags[1];
        return {rs1_used, rs2_used};
    endfunction

    // Comment and blank lines are skipped
    // Command lines need all 19 columns
    task automatic load_vectors();
        int          fd;
        int          rc;
        int          line_no;
        int          f_group;
        string       line;
        byte         first;
        logic [7:0]  cmd;
        logic [31:0] valid;
        logic [31:0] instr;
        logic [31:0] stl;
        logic [31:0] fls;
        logic [31:0] wbe;
        logic [31:0] wbrd;
        logic [31:0] wbdata;
        logic [31:0] evld;
        logic [31:0] flags;
        logic [31:0] iop;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] f3;
        logic [31:0] imm;
        logic [31:0] rs1d;
        logic [31:0] rs2d;
        vector_s     v;
        load_ok = 1'b1;
        line_no = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("Cannot open the stimulus file %s", STIM_FILE);
            load_ok = 1'b0;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                rc = $fgets(line, fd);
                line_no++;
                first = (line.len() > 0) ? line.getc(0) : "\n";
                if (first != "#" && first != "\n" && first != "\r")
                begin
                    rc = $sscanf(line, "%d %c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 f_group, cmd, valid, instr, stl, fls, wbe, wbrd, wbdata,
                                 evld, flags, iop, rd, rs1, rs2, f3, imm, rs1d, rs2d);
                    if (rc != 19)
                    begin
                        $display("Stimulus line %0d has the wrong number of columns", line_no);
                        load_ok = 1'b0;
                    end
                    else
                    begin
                        v.group        = f_group[7:0];
                        v.cmd          = cmd;
                        v.valid        = valid[0];
                        v.instr        = instr;
                        v.stall        = stl[0];
                        v.flush        = fls[0];
                        v.wb_en        = wbe[0];
                        v.wb_rd        = wbrd[4:0];
                        v.wb_data      = wbdata;
                        v.exp_valid    = evld[0];
                        v.exp_flags    = flags[6:0];
                        v.exp_iop      = iop[0];
                        v.exp_rd       = rd[4:0];
                        v.exp_rs1      = rs1[4:0];
                        v.exp_rs2      = rs2[4:0];
                        v.exp_f3       = f3[2:0];
                        v.exp_imm      = imm;
                        v.exp_rs1_data = rs1d;
                        v.exp_rs2_data = rs2d;
                        vectors.push_back(v);
                    end
                end
            end
            $fclose(fd);
            if (vectors.size() == 0)
            begin
                $display("The stimulus file holds no commands");
                load_ok = 1'b0;
            end
        end
    endtask

    task automatic apply_vector(input vector_s v);
        instr_valid = v.valid;
        instruction = v.instr;
        stall       = v.stall;
        flush       = v.flush;
        wb_en       = v.wb_en;
        wb_rd       = v.wb_rd;
        wb_data     = v.wb_data;
    endtask

    // Write-back lines only check the valid bit
    task automatic check_vector(input vector_s v, input logic [31:0] exp_instr);
        logic [6:0] flags;
        logic [1:0] used;
        flags = {ex.ctrl.load_upper_imm, ex.ctrl.uncond_branch, ex.ctrl.cond_branch,
                 ex.ctrl.mem, ex.ctrl.alu_imm, ex.ctrl.alu_reg, ex.ctrl.illegal};
        used  = sources_used(v.exp_flags, v.exp_iop);
        check_value("o_ex_valid", 32'(v.exp_valid), 32'(ex_valid));
        if (v.cmd != "W")
        begin
            check_value("o_ex.ctrl flags", 32'(v.exp_flags), 32'(flags));
            check_value("o_ex.ctrl.iop", 32'(v.exp_iop), 32'(ex.ctrl.iop));
            check_value("o_ex.ctrl.rd", 32'(v.exp_rd), 32'(ex.ctrl.rd));
            check_value("o_ex.ctrl.rs1", 32'(v.exp_rs1), 32'(ex.ctrl.rs1));
            check_value("o_ex.ctrl.rs1_out", 32'(used[1]), 32'(ex.ctrl.rs1_out));
            check_value("o_ex.ctrl.rs2", 32'(v.exp_rs2), 32'(ex.ctrl.rs2));
            check_value("o_ex.ctrl.rs2_out", 32'(used[0]), 32'(ex.ctrl.rs2_out));
            check_value("o_ex.ctrl.fcs_opcode", 32'(v.exp_f3), 32'(ex.ctrl.fcs_opcode));
            check_value("o_ex.ctrl.debug_instruction", exp_instr,
                        ex.ctrl.debug_instruction);
            check_value("o_ex.imm", v.exp_imm, ex.imm);
            check_value("o_ex.rs1_data", v.exp_rs1_data, ex.rs1_data);
            check_value("o_ex.rs2_data", v.exp_rs2_data, ex.rs2_data);
        end
    endtask

    //////////////////////////////
    // Watchdog
    //////////////////////////////

    initial
    begin
        wait (loaded);
        #(watchdog_ns);
        $display("Run did not finish within %0t", watchdog_ns);
        $display(">>> FAIL");
        $finish;
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        $timeformat(-9, 0, " ns", 0);
        clk           = 1'b0;
        rst           = 1'b1;
        instr_valid   = 1'b0;
        instruction   = '0;
        stall         = 1'b0;
        flush         = 1'b0;
        wb_en         = 1'b0;
        wb_rd         = '0;
        wb_data       = '0;
        loaded        = 1'b0;
        checks        = 0;
        errors        = 0;
        group_checks  = 0;
        group_errors  = 0;
        current_group = RESET_GROUP;
        held_instr    = '0;
        load_vectors();
        if (!load_ok)
        begin
            $display(">>> FAIL");
            $finish;
        end
        else
        begin
            watchdog_ns = time'((vectors.size() + 2 + MARGIN_CYCLES) * CLK_PERIOD);
            loaded = 1'b1;
            // Reset released on a falling edge after two cycles
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst = 1'b0;
            check_value("o_ex_valid", 32'd0, 32'(ex_valid));
            foreach (vectors[i])
            begin
                if (int'(vectors[i].group) != current_group)
                begin
                    finish_group();
                    current_group = int'(vectors[i].group);
                end
                apply_vector(vectors[i]);
                // Instruction word the ID/EX register holds after this edge
                if (vectors[i].flush)
                begin
                    held_instr = '0;
                end
                else if (!vectors[i].stall)
                begin
                    held_instr = vectors[i].instr;
                end
                @(negedge clk);
                check_vector(vectors[i], held_instr);
            end
            finish_group();
            $display("Lines: %0d, checks: %0d, errors: %0d", vectors.size(), checks, errors);
            if (errors == 0)
            begin
                $display(">>> PASS");
            end
            else
            begin
                $display(">>> FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage
(
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_instr_valid,
    input  logic [rapid_pkg::XLEN-1:0]       i_instruction,
    input  logic                             i_stall,
    input  logic                             i_flush,
    output logic [rapid_pkg::REG_ADDR_W-1:0] o_rs1,
    output logic [rapid_pkg::REG_ADDR_W-1:0] o_rs2,
    input  logic [rapid_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [rapid_pkg::XLEN-1:0]       i_rs2_data,
    output rapid_pkg::id_ex_s                o_ex,
    output logic                             o_ex_valid
);

    rapid_pkg::control_ex_s           ctrl;
    logic signed [rapid_pkg::XLEN-1:0] imm;
    rapid_pkg::id_ex_s                ex_next;

    //////////////////////////////
    // Decode
    //////////////////////////////

    decoder_logic u_decoder
    (
        .i_instruction    (i_instruction),
        .o_control_signal (ctrl),
        .o_imm            (imm)
    );

    // Register file indices straight from the instruction fields
    assign o_rs1 = ctrl.rs1;
    assign o_rs2 = ctrl.rs2;

    // Unused operands read as zero
    always_comb
    begin
        ex_next.ctrl     = ctrl;
        ex_next.imm      = imm;
        ex_next.rs1_data = ctrl.rs1_out ? i_rs1_data : '0;
        ex_next.rs2_data = ctrl.rs2_out ? i_rs2_data : '0;
    end

    //////////////////////////////
    // ID/EX register
    //////////////////////////////

    // Flush beats stall, stall holds everything
    always_ff @(posedge i_clk)
    begin
        if (i_rst || i_flush)
        begin
            o_ex.ctrl     <= rapid_pkg::control_ex_s_default();
            o_ex.imm      <= '0;
            o_ex.rs1_data <= '0;
            o_ex.rs2_data <= '0;
            o_ex_valid    <= 1'b0;
        end
        else if (!i_stall)
        begin
            // Invalid slots still load, only valid drops
            o_ex       <= ex_next;
            o_ex_valid <= i_instr_valid;
        end
    end

endmodule

`default_nettype wire

//--- rtl/decoder_logic.sv
`timescale 1ns/1ps
`default_nettype none

module decoder_logic
(
    input  logic        [rapid_pkg::XLEN-1:0] i_instruction,
    output rapid_pkg::control_ex_s             o_control_signal,
    output logic signed [rapid_pkg::XLEN-1:0] o_imm
);

    logic [6:0]                 opcode;
    logic [rapid_pkg::XLEN-1:0] imm_u;
    logic [rapid_pkg::XLEN-1:0] imm_j;
    logic [rapid_pkg::XLEN-1:0] imm_i;
    logic [rapid_pkg::XLEN-1:0] imm_b;
    logic [rapid_pkg::XLEN-1:0] imm_s;

    assign opcode = i_instruction[6:0];

    //////////////////////////////
    // Immediate formats
    //////////////////////////////

    assign imm_u = {i_instruction[31:12], 12'b0};

    assign imm_j = {{11{i_instruction[31]}}, i_instruction[31], i_instruction[19:12],
                    i_instruction[20], i_instruction[30:21], 1'b0};

    assign imm_i = {{20{i_instruction[31]}}, i_instruction[31:20]};

    assign imm_b = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
                    i_instruction[30:25], i_instruction[11:8], 1'b0};

    assign imm_s = {{20{i_instruction[31]}}, i_instruction[31:25], i_instruction[11:7]};

    //////////////////////////////
    // Opcode decode
    //////////////////////////////

    always_comb
    begin
        o_control_signal = rapid_pkg::control_ex_s_default();
        o_imm            = '0;

        o_control_signal.debug_instruction = i_instruction;
        o_control_signal.fcs_opcode        = i_instruction[14:12];

        case (opcode)
            // LUI and AUIPC, bit 5 tells them apart
            rapid_pkg::upper_family,
            rapid_pkg::upper_family & 7'b1011111:
            begin
                o_control_signal.load_upper_imm = 1'b1;
                o_control_signal.iop            = i_instruction[5];
                o_control_signal.rd             = i_instruction[11:7];
                o_imm                           = imm_u;
            end

            rapid_pkg::uncond_branch_jal:
            begin
                o_control_signal.uncond_branch = 1'b1;
                o_control_signal.iop           = 1'b0;
                o_control_signal.rd            = i_instruction[11:7];
                o_imm                          = imm_j;
            end

            // Target base comes from rs1
            rapid_pkg::uncond_branch_jalr:
            begin
                o_control_signal.uncond_branch = 1'b1;
                o_control_signal.iop           = 1'b1;
                o_control_signal.rd            = i_instruction[11:7];
                o_control_signal.rs1           = i_instruction[19:15];
                o_control_signal.rs1_out       = 1'b1;
                o_imm                          = imm_i;
            end

            rapid_pkg::cond_branch_family:
            begin
                o_control_signal.cond_branch = 1'b1;
                o_control_signal.rs1         = i_instruction[19:15];
                o_control_signal.rs1_out     = 1'b1;
                o_control_signal.rs2         = i_instruction[24:20];
                o_control_signal.rs2_out     = 1'b1;
                o_imm                        = imm_b;
            end

            // Address is rs1 + imm, iop stays low for loads
            rapid_pkg::mem_load_family:
            begin
                o_control_signal.mem     = 1'b1;
                o_control_signal.rs1     = i_instruction[19:15];
                o_control_signal.rs1_out = 1'b1;
                o_control_signal.rd      = i_instruction[11:7];
                o_imm                    = imm_i;
            end

            rapid_pkg::mem_store_family:
            begin
                o_control_signal.mem     = 1'b1;
                o_control_signal.iop     = i_instruction[5];
                o_control_signal.rs1     = i_instruction[19:15];
                o_control_signal.rs1_out = 1'b1;
                o_control_signal.rs2     = i_instruction[24:20];
                o_control_signal.rs2_out = 1'b1;
                o_imm                    = imm_s;
            end

            rapid_pkg::imm_family:
            begin
                o_control_signal.alu_imm = 1'b1;
                o_control_signal.iop     = i_instruction[30];
                o_control_signal.rs1     = i_instruction[19:15];
                o_control_signal.rs1_out = 1'b1;
                o_control_signal.rd      = i_instruction[11:7];
                o_imm                    = imm_i;
            end

            // No immediate for R-type
            rapid_pkg::reg_family:
            begin
                o_control_signal.alu_reg = 1'b1;
                o_control_signal.iop     = i_instruction[30];
                o_control_signal.rs1     = i_instruction[19:15];
                o_control_signal.rs1_out = 1'b1;
                o_control_signal.rs2     = i_instruction[24:20];
                o_control_signal.rs2_out = 1'b1;
                o_control_signal.rd      = i_instruction[11:7];
            end

            default:
            begin
                o_control_signal.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rapid_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module rapid_decode_top
(
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_instr_valid,
    input  logic [rapid_pkg::XLEN-1:0]       i_instruction,
    input  logic                             i_stall,
    input  logic                             i_flush,
    input  logic                             i_wb_en,
    input  logic [rapid_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input  logic [rapid_pkg::XLEN-1:0]       i_wb_data,
    output rapid_pkg::id_ex_s                o_ex,
    output logic                             o_ex_valid
);

    logic [rapid_pkg::REG_ADDR_W-1:0] rs1;
    logic [rapid_pkg::REG_ADDR_W-1:0] rs2;
    logic [rapid_pkg::XLEN-1:0]       rs1_data;
    logic [rapid_pkg::XLEN-1:0]       rs2_data;

    decode_stage u_decode_stage
    (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_instr_valid (i_instr_valid),
        .i_instruction (i_instruction),
        .i_stall       (i_stall),
        .i_flush       (i_flush),
        .o_rs1         (rs1),
        .o_rs2         (rs2),
        .i_rs1_data    (rs1_data),
        .i_rs2_data    (rs2_data),
        .o_ex          (o_ex),
        .o_ex_valid    (o_ex_valid)
    );

    // Write-back port comes from outside the stage
    reg_file u_reg_file
    (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_wb_en    (i_wb_en),
        .i_wb_rd    (i_wb_rd),
        .i_wb_data  (i_wb_data),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

endmodule

`default_nettype wire

//--- rtl/rapid_pkg.sv
`default_nettype none

package rapid_pkg;

    //////////////////////////////
    // Machine widths
    //////////////////////////////

    // RV32I integer width
    localparam int XLEN       = 32;

    // Integer register file size
    localparam int REG_COUNT  = 32;
    localparam int REG_ADDR_W = 5;

    //////////////////////////////
    // Major opcodes
    //////////////////////////////

    // LUI here, AUIPC differs only in bit 5
    localparam logic [6:0] upper_family       = 7'b0110111;
    localparam logic [6:0] uncond_branch_jal  = 7'b1101111;
    localparam logic [6:0] uncond_branch_jalr = 7'b1100111;
    // BEQ, BNE, BLT, BGE, BLTU, BGEU
    localparam logic [6:0] cond_branch_family = 7'b1100011;
    // LB, LH, LW, LBU, LHU
    localparam logic [6:0] mem_load_family    = 7'b0000011;
    // SB, SH, SW
    localparam logic [6:0] mem_store_family   = 7'b0100011;
    // ADDI through SRAI
    localparam logic [6:0] imm_family         = 7'b0010011;
    // ADD through AND
    localparam logic [6:0] reg_family         = 7'b0110011;

    //////////////////////////////
    // Control record
    //////////////////////////////

    // Block flags pick the execute unit, iop and fcs_opcode
    // pick the operation inside it
    typedef struct packed {
        logic                  load_upper_imm;
        logic                  uncond_branch;
        logic                  cond_branch;
        logic                  mem;
        logic                  alu_imm;
        logic                  alu_reg;
        // Opcode not recognized
        logic                  illegal;
        // Invert op: AUIPC/LUI, JAL/JALR, load/store, add/sub
        logic                  iop;
        logic [REG_ADDR_W-1:0] rs1;
        logic                  rs1_out;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  rs2_out;
        logic [REG_ADDR_W-1:0] rd;
        // funct3
        logic [2:0]            fcs_opcode;
        // Raw word kept for trace
        logic [XLEN-1:0]       debug_instruction;
    } control_ex_s;

    //////////////////////////////
    // ID/EX record
    //////////////////////////////

    typedef struct packed {
        control_ex_s            ctrl;
        logic signed [XLEN-1:0] imm;
        logic [XLEN-1:0]        rs1_data;
        logic [XLEN-1:0]        rs2_data;
    } id_ex_s;

    // Idle control record, no block selected
    function automatic control_ex_s control_ex_s_default();
        control_ex_s ctrl;
        ctrl = '0;
        return ctrl;
    endfunction

endpackage

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
(
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_wb_en,
    input  logic [rapid_pkg::REG_ADDR_W-1:0] i_wb_rd,
    input  logic [rapid_pkg::XLEN-1:0]       i_wb_data,
    input  logic [rapid_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [rapid_pkg::REG_ADDR_W-1:0] i_rs2,
    output logic [rapid_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rapid_pkg::XLEN-1:0]       o_rs2_data
);

    logic [rapid_pkg::XLEN-1:0] regs [rapid_pkg::REG_COUNT];

    // Write-back, x0 never written
    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < rapid_pkg::REG_COUNT; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (i_wb_en && (i_wb_rd != '0))
        begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // One read port, same-cycle write wins over stored value
    function automatic logic [rapid_pkg::XLEN-1:0] read_reg(
        input logic [rapid_pkg::REG_ADDR_W-1:0] addr
    );
        logic [rapid_pkg::XLEN-1:0] value;
        if (addr == '0)
            value = '0;
        else if (i_wb_en && (i_wb_rd == addr))
            value = i_wb_data;
        else
            value = regs[addr];
        return value;
    endfunction

    always_comb
    begin
        o_rs1_data = read_reg(i_rs1);
        o_rs2_data = read_reg(i_rs2);
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the decode-stage testbench with Verilator and run it.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

TOP=tb_rapid_decode
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps \
    --top-module "$TOP" -Mdir "$OBJ_DIR" -o "$TOP" -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

grep -qx ">>> PASS" "$LOG"
if [ $? -ne 0 ]; then
    echo "Simulation did not pass, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
